// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_adc_capture
FILELIST  := adc_capture_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== adc_capture_top.f ====
+incdir+common
common/adc_pkg.sv
common/host_pkg.sv
adc_phy/frame_aligner.sv
capture/capture_ctrl.sv
capture/capture_buffer.sv
host/host_regs.sv
rtl/adc_capture_top.sv
verif/tb_adc_capture.sv

// ==== adc_phy/frame_aligner.sv ====
`timescale 1ns/1ps
`include "adc_capture_params.svh"

module frame_aligner import adc_pkg::*, host_pkg::*; (
	input  logic         data_clk_div,
	input  logic         rst_n,
	input  ctrl_t        ctrl,
	input  lane_words_t  lanes,
	output sample_pair_t sample,
	output logic         frame_valid,
	output logic [2:0]   bitslip_count
);

	localparam int WAIT_W = $clog2(`SLIP_SETTLE + 1);

	align_state_e      state;
	logic [WAIT_W-1:0] wait_cnt;
	logic              frame_match;

	// each slip moves the byte one bit toward the lsb
	function automatic logic [`LANE_W-1:0] slip(input logic [`LANE_W-1:0] b,
			input logic [2:0] n);
		logic [2*`LANE_W-1:0] dbl;
		dbl = {b, b} >> n;
		return dbl[`LANE_W-1:0];
	endfunction

	assign frame_match = (slip(lanes.frame, bitslip_count) == `FRAME_PATTERN);

	// a lane in the upper byte, b lane in the lower
	always_ff @(posedge data_clk_div) begin
		sample.ch0 <= {slip(lanes.ch0_a, bitslip_count), slip(lanes.ch0_b, bitslip_count)};
		sample.ch1 <= {slip(lanes.ch1_a, bitslip_count), slip(lanes.ch1_b, bitslip_count)};
	end

	always_ff @(posedge data_clk_div or negedge rst_n) begin
		if (!rst_n) begin
			state <= ALIGN_IDLE;
			bitslip_count <= '0;
			frame_valid <= 1'b0;
			wait_cnt <= '0;
		end else if (!ctrl.adc_enable) begin
			state <= ALIGN_IDLE;
			bitslip_count <= '0;
			frame_valid <= 1'b0;
			wait_cnt <= '0;
		end else begin
			case (state)
				ALIGN_IDLE: begin
					state <= ALIGN_CHECK;
				end
				ALIGN_CHECK: begin
					if (frame_match) begin
						state <= ALIGN_LOCKED;
						frame_valid <= 1'b1;
					end else begin
						bitslip_count <= bitslip_count + 3'd1;
						wait_cnt <= WAIT_W'(`SLIP_SETTLE - 1);
						state <= ALIGN_WAIT;
					end
				end
				ALIGN_WAIT: begin
					if (wait_cnt == '0)
						state <= ALIGN_CHECK;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				ALIGN_LOCKED: begin
					// search again from the current slip when the frame is lost
					if (!frame_match) begin
						frame_valid <= 1'b0;
						state <= ALIGN_CHECK;
					end
				end
				default: state <= ALIGN_IDLE;
			endcase
		end
	end

endmodule

// ==== capture/capture_buffer.sv ====
`timescale 1ns/1ps
`include "adc_capture_params.svh"

module capture_buffer import adc_pkg::*; (
	input  logic                   data_clk_div,
	input  logic                   wr_en,
	input  logic [`CAP_ADDR_W-1:0] wr_addr,
	input  sample_pair_t           wr_data,
	input  logic [`CAP_ADDR_W-1:0] rd_addr,
	output sample_pair_t           rd_data
);

	sample_pair_t mem [`CAP_DEPTH];

	always_ff @(posedge data_clk_div) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read one cycle after the address
	always_ff @(posedge data_clk_div) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== capture/capture_ctrl.sv ====
`timescale 1ns/1ps
`include "adc_capture_params.svh"

module capture_ctrl import adc_pkg::*, host_pkg::*; (
	input  logic                   data_clk_div,
	input  logic                   rst_n,
	input  ctrl_t                  ctrl,
	output logic                   wr_en,
	output logic [`CAP_ADDR_W-1:0] wr_addr,
	output cap_state_e             cap_state
);

	logic cap_en_q;
	logic start;
	logic last;

	assign start = ctrl.capture_enable & ~cap_en_q;
	assign last = (wr_addr == `CAP_ADDR_W'(`CAP_DEPTH - 1));

	// one entry per cycle while running
	assign wr_en = (cap_state == CAP_RUN);

	always_ff @(posedge data_clk_div or negedge rst_n) begin
		if (!rst_n) begin
			cap_en_q <= 1'b0;
			cap_state <= CAP_IDLE;
			wr_addr <= '0;
		end else begin
			cap_en_q <= ctrl.capture_enable;
			if (!ctrl.capture_enable) begin
				cap_state <= CAP_IDLE;
				wr_addr <= '0;
			end else begin
				case (cap_state)
					CAP_IDLE: begin
						if (start) begin
							cap_state <= CAP_RUN;
							wr_addr <= '0;
						end
					end
					CAP_RUN: begin
						// stop on the last entry without wrapping
						if (last)
							cap_state <= CAP_DONE;
						else
							wr_addr <= wr_addr + 1'b1;
					end
					CAP_DONE: cap_state <= CAP_DONE;
					default: cap_state <= CAP_IDLE;
				endcase
			end
		end
	end

endmodule

// ==== common/adc_capture_params.svh ====
`ifndef ADC_CAPTURE_PARAMS_SVH
`define ADC_CAPTURE_PARAMS_SVH

// frame byte seen once the lanes are aligned
`define FRAME_PATTERN 8'b1111_0000

// cycles to wait after a slip before the next compare
`define SLIP_SETTLE 2

// lane byte and assembled sample widths
`define LANE_W 8
`define SAMPLE_W 16

// capture buffer geometry
`define CAP_ADDR_W 6
`define CAP_DEPTH 64

`endif

// ==== common/adc_pkg.sv ====
`include "adc_capture_params.svh"

package adc_pkg;

	// one deserialized word per lane and cycle
	typedef struct packed {
		logic [`LANE_W-1:0] frame;
		logic [`LANE_W-1:0] ch0_a;
		logic [`LANE_W-1:0] ch0_b;
		logic [`LANE_W-1:0] ch1_a;
		logic [`LANE_W-1:0] ch1_b;
	} lane_words_t;

	// buffer word with ch0 in the upper half
	typedef struct packed {
		logic [`SAMPLE_W-1:0] ch0;
		logic [`SAMPLE_W-1:0] ch1;
	} sample_pair_t;

	typedef enum logic [1:0] {
		ALIGN_IDLE,
		ALIGN_CHECK,
		ALIGN_WAIT,
		ALIGN_LOCKED
	} align_state_e;

	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_RUN,
		CAP_DONE
	} cap_state_e;

endpackage

// ==== common/host_pkg.sv ====
`include "adc_capture_params.svh"

package host_pkg;

	typedef enum logic [1:0] {
		CMD_WRITE_CTRL,
		CMD_READ_STATUS,
		CMD_READ_SAMPLE
	} host_cmd_e;

	typedef struct packed {
		host_cmd_e cmd;
		logic [`CAP_ADDR_W-1:0] addr;
		logic [31:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic [31:0] rdata;
	} host_rsp_t;

	// wdata[1] is adc_enable, wdata[0] is capture_enable
	typedef struct packed {
		logic adc_enable;
		logic capture_enable;
	} ctrl_t;

	typedef struct packed {
		logic frame_valid;
		logic [2:0] bitslip_count;
		adc_pkg::cap_state_e cap_state;
		logic adc_enable;
		logic capture_enable;
	} status_t;

endpackage

// ==== host/host_regs.sv ====
`timescale 1ns/1ps
`include "adc_capture_params.svh"

module host_regs import adc_pkg::*, host_pkg::*; (
	input  logic                   data_clk_div,
	input  logic                   rst_n,
	input  host_req_t              host_req,
	input  logic                   host_req_valid,
	output logic                   host_ack,
	output host_rsp_t              host_rsp,
	output ctrl_t                  ctrl,
	output logic [`CAP_ADDR_W-1:0] rd_addr,
	input  sample_pair_t           rd_data,
	input  logic                   frame_valid,
	input  logic [2:0]             bitslip_count,
	input  cap_state_e             cap_state
);

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACCEPT,
		HS_RESPOND,
		HS_RELEASE
	} hs_state_e;

	hs_state_e   hs_state;
	host_req_t   req_q;
	status_t     status;
	logic [31:0] rdata_mux;

	assign rd_addr = req_q.addr;

	always_comb begin
		status.frame_valid = frame_valid;
		status.bitslip_count = bitslip_count;
		status.cap_state = cap_state;
		status.adc_enable = ctrl.adc_enable;
		status.capture_enable = ctrl.capture_enable;
	end

	// writes answer with zero
	always_comb begin
		case (req_q.cmd)
			CMD_READ_STATUS: rdata_mux = 32'(status);
			CMD_READ_SAMPLE: rdata_mux = rd_data;
			default: rdata_mux = '0;
		endcase
	end

	// latched request and response word
	always_ff @(posedge data_clk_div) begin
		if (hs_state == HS_IDLE && host_req_valid)
			req_q <= host_req;
		if (hs_state == HS_RESPOND)
			host_rsp.rdata <= rdata_mux;
	end

	always_ff @(posedge data_clk_div or negedge rst_n) begin
		if (!rst_n) begin
			hs_state <= HS_IDLE;
			host_ack <= 1'b0;
			ctrl <= '0;
		end else begin
			case (hs_state)
				HS_IDLE: begin
					if (host_req_valid)
						hs_state <= HS_ACCEPT;
				end
				HS_ACCEPT: begin
					// buffer read in flight
					hs_state <= HS_RESPOND;
				end
				HS_RESPOND: begin
					if (req_q.cmd == CMD_WRITE_CTRL)
						ctrl <= ctrl_t'(req_q.wdata[1:0]);
					host_ack <= 1'b1;
					hs_state <= HS_RELEASE;
				end
				HS_RELEASE: begin
					// hold ack until the host lets go
					if (!host_req_valid) begin
						host_ack <= 1'b0;
						hs_state <= HS_IDLE;
					end
				end
				default: hs_state <= HS_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/adc_capture_top.sv ====
`timescale 1ns/1ps
`include "adc_capture_params.svh"

module adc_capture_top import adc_pkg::*, host_pkg::*; (
	input  logic        data_clk_div,
	input  logic        rst_n,
	input  lane_words_t lanes,
	input  host_req_t   host_req,
	input  logic        host_req_valid,
	output logic        host_ack,
	output host_rsp_t   host_rsp
);

	ctrl_t                  ctrl;
	sample_pair_t           sample;
	sample_pair_t           rd_data;
	logic                   frame_valid;
	logic [2:0]             bitslip_count;
	logic                   wr_en;
	logic [`CAP_ADDR_W-1:0] wr_addr;
	logic [`CAP_ADDR_W-1:0] rd_addr;
	cap_state_e             cap_state;

	frame_aligner frame_aligner_i (
		.data_clk_div  (data_clk_div),
		.rst_n         (rst_n),
		.ctrl          (ctrl),
		.lanes         (lanes),
		.sample        (sample),
		.frame_valid   (frame_valid),
		.bitslip_count (bitslip_count)
	);

	capture_ctrl capture_ctrl_i (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.ctrl         (ctrl),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.cap_state    (cap_state)
	);

	// aligned sample goes straight into the buffer
	capture_buffer capture_buffer_i (
		.data_clk_div (data_clk_div),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (sample),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data)
	);

	host_regs host_regs_i (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.host_req       (host_req),
		.host_req_valid (host_req_valid),
		.host_ack       (host_ack),
		.host_rsp       (host_rsp),
		.ctrl           (ctrl),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.frame_valid    (frame_valid),
		.bitslip_count  (bitslip_count),
		.cap_state      (cap_state)
	);

endmodule

// ==== verif/tb_adc_capture.sv ====
`timescale 1ns/1ps
`include "adc_capture_params.svh"

module tb_adc_capture import adc_pkg::*, host_pkg::*; ();

	localparam int ROWS = 8;
	localparam int ACK_WAIT = 10;
	localparam int POLLS = 40;
	localparam int WATCHDOG_NS = ROWS * (`CAP_DEPTH + 200) * 4;

	typedef struct packed {
		logic [2:0]  k;
		logic [15:0] mask;
		logic        run;
	} stim_row_t;

	// slip k, ch1 mask, capture pass
	localparam stim_row_t STIM [ROWS] = '{
		'{3'd0, 16'h0000, 1'b1},
		'{3'd3, 16'h00ff, 1'b0},
		'{3'd5, 16'hffff, 1'b1},
		'{3'd1, 16'h1234, 1'b0},
		'{3'd7, 16'h8001, 1'b0},
		'{3'd2, 16'h5a5a, 1'b1},
		'{3'd4, 16'h0f0f, 1'b0},
		'{3'd6, 16'hc3c3, 1'b0}
	};

	logic        data_clk_div;
	logic        rst_n;
	lane_words_t lanes;
	host_req_t   host_req;
	logic        host_req_valid;
	logic        host_ack;
	host_rsp_t   host_rsp;

	logic        req_pending;
	logic [2:0]  lane_k;
	logic [15:0] lane_mask;
	logic [15:0] ramp_ofs;
	logic [15:0] cyc;
	logic [15:0] ramp;
	logic [31:0] lcg_state;

	adc_capture_top dut_i (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.lanes          (lanes),
		.host_req       (host_req),
		.host_req_valid (host_req_valid),
		.host_ack       (host_ack),
		.host_rsp       (host_rsp)
	);

	always #2 data_clk_div = ~data_clk_div;

	function automatic logic [7:0] rotate_right(input logic [7:0] b, input logic [2:0] n);
		rotate_right = (b >> n) | (b << (8 - int'(n)));
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		lcg_next = s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic status_t expect_status(input logic fv, input logic [2:0] cnt,
			input cap_state_e cs, input logic adc, input logic cap);
		expect_status = '{fv, cnt, cs, adc, cap};
	endfunction

	function automatic string status_text(input status_t s);
		status_text = $sformatf("fv=%b cnt=%0d %s en=%b%b", s.frame_valid, s.bitslip_count,
			s.cap_state.name(), s.adc_enable, s.capture_enable);
	endfunction

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			fail_now($sformatf("ERROR at %0d ns: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	task automatic check_status(input status_t got, input status_t exp, input string what);
		if (got !== exp)
			fail_now($sformatf("ERROR at %0d ns: %s got %s expected %s", $time, what,
				status_text(got), status_text(exp)));
	endtask

	task automatic check_sample(input sample_pair_t got, input sample_pair_t exp,
			input string what);
		if (got !== exp)
			fail_now($sformatf("ERROR at %0d ns: %s got %h/%h expected %h/%h",
				$time, what, got.ch0, got.ch1, exp.ch0, exp.ch1));
	endtask

	task automatic check_rsp(input host_rsp_t got, input host_rsp_t exp, input string what);
		if (got !== exp)
			fail_now($sformatf("ERROR at %0d ns: %s got %h expected %h",
				$time, what, got.rdata, exp.rdata));
	endtask

	// full four-phase transfer entered and left 1 ns after a rising edge
	task automatic host_xfer(input host_cmd_e cmd, input logic [`CAP_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output host_rsp_t rsp);
		int n;
		check_flag(host_ack, 1'b0, "host_ack before request");
		host_req.cmd = cmd;
		host_req.addr = addr;
		host_req.wdata = wdata;
		host_req_valid = 1'b1;
		req_pending = 1'b1;
		n = 0;
		while (!host_ack) begin
			@(posedge data_clk_div);
			#1;
			n++;
			if (n > ACK_WAIT)
				fail_now("host_ack never rose after host_req_valid was raised");
		end
		rsp = host_rsp;
		// request still held so ack and response must stay put
		@(posedge data_clk_div);
		#1;
		check_flag(host_ack, 1'b1, "host_ack while request held");
		check_rsp(host_rsp, rsp, "held response");
		host_req_valid = 1'b0;
		n = 0;
		while (host_ack) begin
			@(posedge data_clk_div);
			#1;
			n++;
			if (n > ACK_WAIT)
				fail_now("host_ack never fell after host_req_valid was dropped");
		end
		req_pending = 1'b0;
	endtask

	task automatic write_ctrl(input logic adc, input logic cap);
		host_rsp_t rsp;
		host_xfer(CMD_WRITE_CTRL, '0, {30'd0, adc, cap}, rsp);
		check_rsp(rsp, '0, "write response");
	endtask

	task automatic read_status(output status_t st);
		host_rsp_t rsp;
		host_xfer(CMD_READ_STATUS, '0, 32'd0, rsp);
		st = status_t'(rsp.rdata[7:0]);
		check_rsp(rsp, host_rsp_t'({24'd0, rsp.rdata[7:0]}), "status upper bits");
	endtask

	task automatic wait_for_lock(output status_t st);
		int n;
		n = 0;
		read_status(st);
		while (!st.frame_valid) begin
			n++;
			if (n > POLLS)
				fail_now("frame_valid never rose after adc_enable was set");
			read_status(st);
		end
	endtask

	task automatic wait_for_done(output status_t st);
		int n;
		n = 0;
		read_status(st);
		while (st.cap_state != CAP_DONE) begin
			n++;
			if (n > POLLS)
				fail_now("capture never reached CAP_DONE after capture_enable rose");
			read_status(st);
		end
	endtask

	// load a new slip, mask and ramp start between lane updates
	task automatic set_lane_pattern(input logic [2:0] k, input logic [15:0] mask,
			input logic [15:0] start);
		@(negedge data_clk_div);
		lane_k = k;
		lane_mask = mask;
		ramp_ofs = start - cyc;
		@(posedge data_clk_div);
		#1;
	endtask

	task automatic check_buffer(input logic [15:0] mask, input logic [15:0] start);
		host_rsp_t    rsp;
		sample_pair_t got;
		sample_pair_t exp;
		logic [15:0]  first;
		for (int i = 0; i < `CAP_DEPTH; i++) begin
			host_xfer(CMD_READ_SAMPLE, `CAP_ADDR_W'(i), 32'd0, rsp);
			got = sample_pair_t'(rsp.rdata);
			if (i == 0) begin
				first = got.ch0;
				// stale data from an older pass would sit outside this window
				if (16'(first - start) > 16'd200)
					fail_now($sformatf("ERROR at %0d ns: entry 0 ch0 %h not from ramp at %h",
						$time, first, start));
			end
			exp.ch0 = first + 16'(i);
			exp.ch1 = exp.ch0 ^ mask;
			check_sample(got, exp, $sformatf("buffer entry %0d", i));
		end
	endtask

	task automatic run_row(input stim_row_t row);
		status_t     st;
		logic [15:0] start;
		logic [2:0]  cnt;
		cnt = 3'(8 - int'(row.k));
		lcg_state = lcg_next(lcg_state);
		start = lcg_state[31:16];
		set_lane_pattern(row.k, row.mask, start);
		write_ctrl(1'b1, 1'b0);
		wait_for_lock(st);
		check_status(st, expect_status(1'b1, cnt, CAP_IDLE, 1'b1, 1'b0), "status after lock");
		if (row.run) begin
			write_ctrl(1'b1, 1'b1);
			wait_for_done(st);
			check_status(st, expect_status(1'b1, cnt, CAP_DONE, 1'b1, 1'b1), "status after pass");
			check_buffer(row.mask, start);
			write_ctrl(1'b1, 1'b0);
			read_status(st);
			check_status(st, expect_status(1'b1, cnt, CAP_IDLE, 1'b1, 1'b0), "status after disarm");
		end
		write_ctrl(1'b0, 1'b0);
		read_status(st);
		check_status(st, expect_status(1'b0, 3'd0, CAP_IDLE, 1'b0, 1'b0), "status after adc off");
	endtask

	// lanes arrive rotated right by the row slip
	always @(posedge data_clk_div) begin
		#1;
		ramp = cyc + ramp_ofs;
		lanes.frame = rotate_right(`FRAME_PATTERN, lane_k);
		lanes.ch0_a = rotate_right(ramp[15:8], lane_k);
		lanes.ch0_b = rotate_right(ramp[7:0], lane_k);
		lanes.ch1_a = rotate_right(ramp[15:8] ^ lane_mask[15:8], lane_k);
		lanes.ch1_b = rotate_right(ramp[7:0] ^ lane_mask[7:0], lane_k);
		cyc = cyc + 16'd1;
	end

	always @(negedge data_clk_div) begin
		if (rst_n && host_ack && !req_pending)
			fail_now("host_ack was high while no request was pending");
	end

	initial begin
		#(WATCHDOG_NS);
		fail_now("watchdog expired before the test sequence finished");
	end

	initial begin
		status_t st;
		data_clk_div = 1'b0;
		rst_n = 1'b0;
		lanes = '0;
		host_req = '0;
		host_req_valid = 1'b0;
		req_pending = 1'b0;
		lane_k = 3'd0;
		lane_mask = 16'h0000;
		ramp_ofs = 16'h0000;
		cyc = 16'h0000;
		ramp = 16'h0000;
		lcg_state = 32'd13;
		repeat (3) @(posedge data_clk_div);
		#1;
		rst_n = 1'b1;
		@(posedge data_clk_div);
		#1;
		check_flag(host_ack, 1'b0, "host_ack after reset");
		read_status(st);
		check_status(st, expect_status(1'b0, 3'd0, CAP_IDLE, 1'b0, 1'b0), "status after reset");
		for (int r = 0; r < ROWS; r++)
			run_row(STIM[r]);
		$display("TEST PASSED");
		$finish;
	end

endmodule
